// File: src/lsu_defines.svh
// data memory subsystem sizes: data width, address width and RAM depth
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// data word width in bits, the design is 32-bit specific
`define LSU_DW 32

// byte address width in bits
`define LSU_AW 32

// RAM depth in words
// any byte address at or above 4 * DRAM_WORDS answers with err
`define DRAM_WORDS 64

`endif

// File: src/lsu_pkg.sv
// load/store instruction types: memory opcodes, unit states and opcode decode helpers
package lsu_pkg;

  typedef enum logic [3:0] {
    LBZ = 4'h0,  // load byte, zero-extend
    LBS = 4'h1,  // load byte, sign-extend
    LHZ = 4'h2,  // load halfword, zero-extend
    LHS = 4'h3,  // load halfword, sign-extend
    LWZ = 4'h4,  // load word
    SB  = 4'h5,  // store byte
    SH  = 4'h6,  // store halfword
    SW  = 4'h7   // store word
  } lsu_op_e;

  typedef enum logic [1:0] {
    IDLE = 2'd0,  // waiting for exec
    REQ  = 2'd1,  // bus request open
    DONE = 2'd2   // result valid, done pulse
  } lsu_state_e;

  function automatic logic op_is_store(lsu_op_e op);
    return op inside {SB, SH, SW};
  endfunction

  function automatic logic op_is_byte(lsu_op_e op);
    return op inside {LBZ, LBS, SB};
  endfunction

  function automatic logic op_is_half(lsu_op_e op);
    return op inside {LHZ, LHS, SH};
  endfunction

  function automatic logic op_is_signed(lsu_op_e op);
    return op inside {LBS, LHS};
  endfunction

endpackage

// File: src/dbus_pkg.sv
// data bus types: byte selects, data word and arbiter grant
`include "lsu_defines.svh"

package dbus_pkg;

  // one bit per byte lane, bit 3 is the lowest address (big endian)
  typedef logic [3:0] bsel_t;

  // one bus data word
  typedef logic [`LSU_DW-1:0] dword_t;

  // owner of the last or the open transfer
  typedef enum logic {
    GNT_A = 1'b0,
    GNT_B = 1'b1
  } grant_e;

endpackage

// File: src/dbus_if.sv
// data bus for one master: request fields to the slave, ack/err/rdat back
`timescale 1ns/1ns
`include "lsu_defines.svh"

interface dbus_if import dbus_pkg::*; ();

  logic               req;   // held until ack or err
  logic [`LSU_AW-1:0] adr;   // byte address
  logic               we;    // 1 = store
  bsel_t              bsel;  // active byte lanes
  dword_t             wdat;  // store data, already lane-replicated
  logic               ack;   // one-cycle response, ok
  logic               err;   // one-cycle response, failed
  dword_t             rdat;  // read word, valid with ack

  modport master (
    output req, adr, we, bsel, wdat,
    input  ack, err, rdat
  );

  modport slave (
    input  req, adr, we, bsel, wdat,
    output ack, err, rdat
  );

endinterface

// File: src/lsu.sv
// load/store unit: one bus access per operation, big-endian lanes, alignment check, load extension
`timescale 1ns/1ns
`include "lsu_defines.svh"

module lsu import lsu_pkg::*, dbus_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               exec_i,          // one-cycle issue pulse
  input  lsu_op_e            opc_i,
  input  logic [`LSU_AW-1:0] adr_i,
  input  dword_t             wdata_i,         // store operand, low bits used for sb/sh
  output logic               busy_o,
  output logic               done_o,          // one-cycle pulse
  output dword_t             result_o,        // held until next exec
  output logic               except_align_o,
  output logic               except_bus_o,
  dbus_if.master             bus
);

  lsu_state_e         state_q;
  lsu_op_e            opc_q;           // registered operation
  logic [`LSU_AW-1:0] adr_q;
  dword_t             wdat_q;
  dword_t             result_q;
  logic               except_align_q;
  logic               except_bus_q;
  logic               accept;          // exec taken this cycle
  logic               misalign;
  bsel_t              bsel;
  dword_t             wdat_rep;        // store data across lanes
  dword_t             rdat_aligned;    // addressed byte moved to the top
  dword_t             rdat_ext;

  assign accept = exec_i && (state_q == IDLE);

  // checked on the incoming op, so no bus cycle starts for a bad address
  assign misalign = (!op_is_byte(opc_i) && !op_is_half(opc_i) && (adr_i[1:0] != 2'b00)) ||
                    (op_is_half(opc_i) && adr_i[0]);

  // unit FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q        <= IDLE;
      except_align_q <= 1'b0;
      except_bus_q   <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            except_align_q <= misalign;
            except_bus_q   <= 1'b0;
            state_q        <= misalign ? DONE : REQ;  // bad alignment skips the bus
          end
        end
        REQ: begin
          if (bus.ack) begin
            state_q <= DONE;
          end else if (bus.err) begin
            except_bus_q <= 1'b1;
            state_q      <= DONE;
          end
        end
        DONE: state_q <= IDLE;  // done pulse lasts one cycle
        default: state_q <= IDLE;
      endcase
    end
  end

  // operation and result registers
  always_ff @(posedge clk) begin
    if (accept) begin
      opc_q    <= opc_i;
      adr_q    <= adr_i;
      wdat_q   <= wdata_i;
      result_q <= '0;  // stores, faults leave zero
    end else if ((state_q == REQ) && bus.ack && !op_is_store(opc_q)) begin
      result_q <= rdat_ext;
    end
  end

  // big endian lane map
  always_comb begin
    if (op_is_byte(opc_q)) begin
      case (adr_q[1:0])
        2'b00:   bsel = 4'b1000;  // msb lane
        2'b01:   bsel = 4'b0100;
        2'b10:   bsel = 4'b0010;
        default: bsel = 4'b0001;
      endcase
    end else if (op_is_half(opc_q)) begin
      bsel = adr_q[1] ? 4'b0011 : 4'b1100;
    end else begin
      bsel = 4'b1111;
    end
  end

  // replicate store data so any lane sees it
  always_comb begin
    if (op_is_byte(opc_q)) begin
      wdat_rep = {4{wdat_q[7:0]}};
    end else if (op_is_half(opc_q)) begin
      wdat_rep = {2{wdat_q[15:0]}};
    end else begin
      wdat_rep = wdat_q;
    end
  end

  assign rdat_aligned = bus.rdat << {adr_q[1:0], 3'b000};  // byte 0 is the msb

  // zero or sign extension of the selected part
  always_comb begin
    if (op_is_byte(opc_q)) begin
      rdat_ext = {{24{op_is_signed(opc_q) & rdat_aligned[31]}}, rdat_aligned[31:24]};
    end else if (op_is_half(opc_q)) begin
      rdat_ext = {{16{op_is_signed(opc_q) & rdat_aligned[31]}}, rdat_aligned[31:16]};
    end else begin
      rdat_ext = rdat_aligned;
    end
  end

  // bus side, fields come from registers and stay stable under req
  assign bus.req  = (state_q == REQ);
  assign bus.adr  = adr_q;
  assign bus.we   = op_is_store(opc_q);
  assign bus.bsel = bsel;
  assign bus.wdat = wdat_rep;

  // pipeline side
  assign busy_o         = (state_q != IDLE);
  assign done_o         = (state_q == DONE);
  assign result_o       = result_q;
  assign except_align_o = except_align_q;
  assign except_bus_o   = except_bus_q;

endmodule

// File: src/dbus_arbiter.sv
// round-robin bus arbiter: two masters share one slave, response goes to the owner only
`timescale 1ns/1ns

module dbus_arbiter import dbus_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  dbus_if.slave  bus_a,
  dbus_if.slave  bus_b,
  dbus_if.master bus_ram
);

  grant_e gnt_q;    // owner of the open or the last transfer
  grant_e gnt_sel;  // owner this cycle
  logic   lock_q;   // transfer open, grant frozen
  logic   gnt_a;
  logic   gnt_b;
  logic   rsp;      // ack or err from the slave

  // pick the owner, the one not served last wins a tie
  always_comb begin
    gnt_sel = gnt_q;
    if (!lock_q) begin
      if (bus_a.req && bus_b.req) begin
        gnt_sel = (gnt_q == GNT_A) ? GNT_B : GNT_A;
      end else if (bus_a.req) begin
        gnt_sel = GNT_A;
      end else if (bus_b.req) begin
        gnt_sel = GNT_B;
      end
    end
  end

  assign gnt_a = (gnt_sel == GNT_A);
  assign gnt_b = (gnt_sel == GNT_B);
  assign rsp   = bus_ram.ack | bus_ram.err;

  // lock on a forwarded request, release after the response
  always_ff @(posedge clk) begin
    if (rst) begin
      gnt_q  <= GNT_B;  // so A wins the first tie
      lock_q <= 1'b0;
    end else if (!lock_q) begin
      if (bus_ram.req) begin
        lock_q <= 1'b1;
        gnt_q  <= gnt_sel;
      end
    end else if (rsp) begin
      lock_q <= 1'b0;
    end
  end

  // request fields of the owner to the slave
  assign bus_ram.req  = gnt_a ? bus_a.req  : bus_b.req;
  assign bus_ram.adr  = gnt_a ? bus_a.adr  : bus_b.adr;
  assign bus_ram.we   = gnt_a ? bus_a.we   : bus_b.we;
  assign bus_ram.bsel = gnt_a ? bus_a.bsel : bus_b.bsel;
  assign bus_ram.wdat = gnt_a ? bus_a.wdat : bus_b.wdat;

  // response only to the owner, the waiting master sees nothing
  assign bus_a.ack  = gnt_a & bus_ram.ack;
  assign bus_a.err  = gnt_a & bus_ram.err;
  assign bus_a.rdat = gnt_a ? bus_ram.rdat : '0;
  assign bus_b.ack  = gnt_b & bus_ram.ack;
  assign bus_b.err  = gnt_b & bus_ram.err;
  assign bus_b.rdat = gnt_b ? bus_ram.rdat : '0;

endmodule

// File: src/data_ram.sv
// data RAM: byte-writable word array, registered ack, err beyond its size
`timescale 1ns/1ns
`include "lsu_defines.svh"

module data_ram import dbus_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  dbus_if.slave bus
);

  localparam int IDX_W = $clog2(`DRAM_WORDS);

  dword_t           mem [`DRAM_WORDS];
  dword_t           rdat_q;
  logic             ack_q;
  logic             err_q;
  logic             accept;    // new request taken this cycle
  logic             in_range;
  logic [IDX_W-1:0] idx;       // word index

  assign accept   = bus.req && !ack_q && !err_q;  // none while a response is out
  assign in_range = (bus.adr[`LSU_AW-1:IDX_W+2] == '0);
  assign idx      = bus.adr[IDX_W+1:2];

  // response flags and byte-lane writes, contents cleared at reset
  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      for (int w = 0; w < `DRAM_WORDS; w++) begin
        mem[w] <= '0;
      end
    end else begin
      ack_q <= accept && in_range;
      err_q <= accept && !in_range;  // out of range writes nothing
      if (accept && in_range && bus.we) begin
        for (int l = 0; l < 4; l++) begin
          if (bus.bsel[l]) begin
            mem[idx][8*l +: 8] <= bus.wdat[8*l +: 8];  // bsel[3] is bits 31:24
          end
        end
      end
    end
  end

  // read word, returned with ack
  always_ff @(posedge clk) begin
    if (accept && in_range) begin
      rdat_q <= mem[idx];
    end
  end

  assign bus.ack  = ack_q;
  assign bus.err  = err_q;
  assign bus.rdat = rdat_q;

endmodule

// File: src/lsu_subsys_top.sv
// data memory subsystem top: two load/store units share one RAM through a round-robin arbiter
`timescale 1ns/1ns
`include "lsu_defines.svh"

module lsu_subsys_top import lsu_pkg::*, dbus_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  // issue port A
  input  logic               a_exec_i,
  input  lsu_op_e            a_opc_i,
  input  logic [`LSU_AW-1:0] a_adr_i,
  input  dword_t             a_wdata_i,
  output logic               a_busy_o,
  output logic               a_done_o,
  output dword_t             a_result_o,
  output logic               a_except_align_o,
  output logic               a_except_bus_o,
  // issue port B
  input  logic               b_exec_i,
  input  lsu_op_e            b_opc_i,
  input  logic [`LSU_AW-1:0] b_adr_i,
  input  dword_t             b_wdata_i,
  output logic               b_busy_o,
  output logic               b_done_o,
  output dword_t             b_result_o,
  output logic               b_except_align_o,
  output logic               b_except_bus_o
);

  dbus_if a_bus ();    // lsu_a to arbiter
  dbus_if b_bus ();    // lsu_b to arbiter
  dbus_if ram_bus ();  // arbiter to RAM

  lsu lsu_a (
    .clk            (clk),
    .rst            (rst),
    .exec_i         (a_exec_i),
    .opc_i          (a_opc_i),
    .adr_i          (a_adr_i),
    .wdata_i        (a_wdata_i),
    .busy_o         (a_busy_o),
    .done_o         (a_done_o),
    .result_o       (a_result_o),
    .except_align_o (a_except_align_o),
    .except_bus_o   (a_except_bus_o),
    .bus            (a_bus.master)
  );

  lsu lsu_b (
    .clk            (clk),
    .rst            (rst),
    .exec_i         (b_exec_i),
    .opc_i          (b_opc_i),
    .adr_i          (b_adr_i),
    .wdata_i        (b_wdata_i),
    .busy_o         (b_busy_o),
    .done_o         (b_done_o),
    .result_o       (b_result_o),
    .except_align_o (b_except_align_o),
    .except_bus_o   (b_except_bus_o),
    .bus            (b_bus.master)
  );

  dbus_arbiter u_arb (
    .clk     (clk),
    .rst     (rst),
    .bus_a   (a_bus.slave),
    .bus_b   (b_bus.slave),
    .bus_ram (ram_bus.master)
  );

  data_ram u_ram (
    .clk (clk),
    .rst (rst),
    .bus (ram_bus.slave)
  );

endmodule

// File: test/lsu_subsys_chk.sv
// handshake and issue assertions for the data memory subsystem, bound to its top level
`timescale 1ns/1ns
`include "lsu_defines.svh"

module lsu_subsys_chk (
  input logic               clk,
  input logic               rst,
  input logic               a_exec_i,
  input logic               a_busy_i,
  input logic               b_exec_i,
  input logic               b_busy_i,
  input logic               a_req_i,
  input logic [`LSU_AW-1:0] a_adr_i,
  input logic               a_rsp_i,    // ack or err routed to A
  input logic               b_req_i,
  input logic [`LSU_AW-1:0] b_adr_i,
  input logic               b_rsp_i,
  input logic               ram_ack_i,
  input logic               ram_err_i
);

  int n_fail = 0;  // failed assertions so far, watched by the testbench

  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    a_req_i && !a_rsp_i |=> a_req_i && $stable(a_adr_i))
    else begin
      n_fail++;
      $error("port A request changed before its response");
    end
  b_req_hold: assert property (@(posedge clk) disable iff (rst)
    b_req_i && !b_rsp_i |=> b_req_i && $stable(b_adr_i))
    else begin
      n_fail++;
      $error("port B request changed before its response");
    end
  a_req_drop: assert property (@(posedge clk) disable iff (rst) a_req_i && a_rsp_i |=> !a_req_i)
    else begin
      n_fail++;
      $error("port A kept req after its response");
    end
  b_req_drop: assert property (@(posedge clk) disable iff (rst) b_req_i && b_rsp_i |=> !b_req_i)
    else begin
      n_fail++;
      $error("port B kept req after its response");
    end
  rsp_onehot: assert property (@(posedge clk) disable iff (rst) !(ram_ack_i && ram_err_i))
    else begin
      n_fail++;
      $error("RAM raised ack and err together");
    end
  a_no_exec_busy: assert property (@(posedge clk) disable iff (rst) a_exec_i |-> !a_busy_i)
    else begin
      n_fail++;
      $error("port A issued while busy");
    end
  b_no_exec_busy: assert property (@(posedge clk) disable iff (rst) b_exec_i |-> !b_busy_i)
    else begin
      n_fail++;
      $error("port B issued while busy");
    end
  // a response reaches one requesting master only
  one_grant: assert property (@(posedge clk) disable iff (rst)
    !(a_rsp_i && b_rsp_i) && (a_rsp_i -> a_req_i) && (b_rsp_i -> b_req_i))
    else begin
      n_fail++;
      $error("response routed to more than one master or to an idle one");
    end

endmodule

bind lsu_subsys_top lsu_subsys_chk chk_inst (
  .clk       (clk),
  .rst       (rst),
  .a_exec_i  (a_exec_i),
  .a_busy_i  (a_busy_o),
  .b_exec_i  (b_exec_i),
  .b_busy_i  (b_busy_o),
  .a_req_i   (a_bus.req),
  .a_adr_i   (a_bus.adr),
  .a_rsp_i   (a_bus.ack | a_bus.err),
  .b_req_i   (b_bus.req),
  .b_adr_i   (b_bus.adr),
  .b_rsp_i   (b_bus.ack | b_bus.err),
  .ram_ack_i (ram_bus.ack),
  .ram_err_i (ram_bus.err)
);

// File: test/tb_lsu_subsys.sv
// testbench for the data memory subsystem: trace-driven issue ports A and B with result checks
`timescale 1ns/1ns
`include "lsu_defines.svh"

module tb_lsu_subsys import lsu_pkg::*, dbus_pkg::*; ();

  typedef struct {
    bit                 port;     // 0 = A, 1 = B
    lsu_op_e            opc;
    logic [`LSU_AW-1:0] adr;
    dword_t             wdata;
    dword_t             exp_res;
    logic [1:0]         exp_exc;  // {align, bus}
  } trace_op_t;

  logic               clk;
  logic               rst;
  logic               a_exec_i, b_exec_i;
  lsu_op_e            a_opc_i, b_opc_i;
  logic [`LSU_AW-1:0] a_adr_i, b_adr_i;
  dword_t             a_wdata_i, b_wdata_i;
  logic               a_busy_o, b_busy_o;
  logic               a_done_o, b_done_o;
  dword_t             a_result_o, b_result_o;
  logic               a_except_align_o, b_except_align_o;
  logic               a_except_bus_o, b_except_bus_o;
  trace_op_t          ops_a[$];  // port A lines in trace order
  trace_op_t          ops_b[$];
  int                 n_ops;     // all trace lines, sizes the watchdog

  lsu_subsys_top lsu_subsys_top_inst (.*);

  always #50 clk = ~clk;  // 100 ns period

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_result(input bit port, input lsu_op_e opc,
                              input dword_t exp, input dword_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("Fail %0t ns port %s %s: result expected %h, got %h",
                              $time, port ? "B" : "A", opc.name(), exp, act));
    end
  endtask

  task automatic check_except(input bit port, input lsu_op_e opc,
                              input logic exp_align, input logic exp_bus,
                              input logic act_align, input logic act_bus);
    if ((act_align !== exp_align) || (act_bus !== exp_bus)) begin
      stop_on_error($sformatf("Fail %0t ns port %s %s: align/bus expected %b%b, got %b%b",
                              $time, port ? "B" : "A", opc.name(),
                              exp_align, exp_bus, act_align, act_bus));
    end
  endtask

  // lines that do not parse into six fields are comments
  task automatic load_trace();
    int                fd;
    int                port;
    int                opc;
    logic [8*160-1:0]  line;
    trace_op_t         op;
    fd = $fopen("test/lsu_trace.txt", "r");
    if (fd == 0) begin
      stop_on_error("Cannot open the trace file test/lsu_trace.txt");
    end
    while (!$feof(fd)) begin
      line = '0;
      void'($fgets(line, fd));
      if ($sscanf(line, "%d %h %h %h %h %b", port, opc, op.adr, op.wdata,
                  op.exp_res, op.exp_exc) == 6) begin
        op.port = port[0];
        op.opc  = lsu_op_e'(opc[3:0]);
        if (op.port) ops_b.push_back(op);
        else ops_a.push_back(op);
        n_ops++;
      end
    end
    $fclose(fd);
    if (n_ops == 0) begin
      stop_on_error("The trace file holds no operations");
    end
  endtask

  // one port's operations in order, inputs change 10 ns after the edge
  task automatic run_port(input bit port);
    trace_op_t op;
    while ((port ? ops_b.size() : ops_a.size()) > 0) begin
      if (port) op = ops_b.pop_front();
      else op = ops_a.pop_front();
      while (port ? b_busy_o : a_busy_o) begin
        @(posedge clk);
        #10;
      end
      repeat ($urandom_range(3)) begin  // idle gap
        @(posedge clk);
        #10;
      end
      if (port) begin
        b_exec_i  = 1'b1;
        b_opc_i   = op.opc;
        b_adr_i   = op.adr;
        b_wdata_i = op.wdata;
      end else begin
        a_exec_i  = 1'b1;
        a_opc_i   = op.opc;
        a_adr_i   = op.adr;
        a_wdata_i = op.wdata;
      end
      @(posedge clk);
      #10;
      if (port) b_exec_i = 1'b0;
      else a_exec_i = 1'b0;
      while (!(port ? b_done_o : a_done_o)) begin  // misaligned ops are done already
        @(posedge clk);
        #10;
      end
      check_except(port, op.opc, op.exp_exc[1], op.exp_exc[0],
                   port ? b_except_align_o : a_except_align_o,
                   port ? b_except_bus_o : a_except_bus_o);
      if (!(op.opc inside {SB, SH, SW}) && (op.exp_exc == 2'b00)) begin
        check_result(port, op.opc, op.exp_res, port ? b_result_o : a_result_o);
      end
    end
  endtask

  // assertion failures in the bound checker
  initial begin
    wait (lsu_subsys_top_inst.chk_inst.n_fail != 0);
    stop_on_error("A bus or issue assertion failed, see the message above");
  end

  initial begin
    void'($urandom(43865));
    clk       = 1'b0;
    rst       = 1'b1;
    a_exec_i  = 1'b0;
    a_opc_i   = LBZ;
    a_adr_i   = '0;
    a_wdata_i = '0;
    b_exec_i  = 1'b0;
    b_opc_i   = LBZ;
    b_adr_i   = '0;
    b_wdata_i = '0;
    n_ops     = 0;
    load_trace();
    fork
      begin  // watchdog, 20 cycles per trace line
        #(n_ops * 20 * 100);
        stop_on_error("Timeout: the trace did not complete in the expected time");
      end
    join_none
    repeat (5) @(posedge clk);
    #10;
    rst = 1'b0;
    fork
      run_port(1'b0);
      run_port(1'b1);
    join
    $display("No errors");
    $finish;
  end

endmodule

// File: test/lsu_trace.txt
# port(0=A 1=B) opcode(0 LBZ 1 LBS 2 LHZ 3 LHS 4 LWZ 5 SB 6 SH 7 SW) address store_data
# expected_result expected_exception(align bus), all hex except port and exception bits
0 7 00000000 11223344 00000000 00
0 4 00000000 00000000 11223344 00
0 4 00000010 00000000 00000000 00
0 5 00000005 000000ab 00000000 00
0 5 00000007 000000cd 00000000 00
0 4 00000004 00000000 00ab00cd 00
0 1 00000005 00000000 ffffffab 00
0 0 00000005 00000000 000000ab 00
0 6 00000008 0000f00d 00000000 00
0 3 00000008 00000000 fffff00d 00
0 2 00000008 00000000 0000f00d 00
0 0 00000003 00000000 00000044 00
0 4 00000002 00000000 00000000 10
0 7 00000001 deadbeef 00000000 10
0 2 00000003 00000000 00000000 10
0 4 00000000 00000000 11223344 00
0 7 00000100 cafef00d 00000000 01
0 4 00000100 00000000 00000000 01
0 4 00000000 00000000 11223344 00
1 7 00000080 a5a5a5a5 00000000 00
1 6 00000082 00001234 00000000 00
1 4 00000080 00000000 a5a51234 00
1 3 00000080 00000000 ffffa5a5 00
1 1 00000083 00000000 00000034 00
1 5 00000084 00000080 00000000 00
1 1 00000084 00000000 ffffff80 00
1 2 00000086 00000000 00000000 00
1 6 00000085 00005555 00000000 10
1 4 00000084 00000000 80000000 00
1 5 000003fc 00000011 00000000 01
1 4 00000080 00000000 a5a51234 00

// File: tb.f
+incdir+src
src/lsu_pkg.sv
src/dbus_pkg.sv
src/dbus_if.sv
src/lsu.sv
src/dbus_arbiter.sv
src/data_ram.sv
src/lsu_subsys_top.sv
test/lsu_subsys_chk.sv
test/tb_lsu_subsys.sv

// File: Bender.yml
package:
  name: lsu_subsys

sources:
  - include_dirs:
      - src
    files:
      - src/lsu_pkg.sv
      - src/dbus_pkg.sv
      - src/dbus_if.sv
      - src/lsu.sv
      - src/dbus_arbiter.sv
      - src/data_ram.sv
      - src/lsu_subsys_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/lsu_subsys_chk.sv
      - test/tb_lsu_subsys.sv
